// ==== design/div_pkg.sv ====
package div_pkg;

    localparam int XLEN = 32;
    localparam int ITERS = XLEN / 2;
    localparam int LZC_W = 5;
    localparam int ROB_LO_W = 16; // widest index body accepted by rob_younger.

    typedef logic [XLEN-1:0] word_t;
    typedef logic [2*XLEN:0] pa_t; // top bit is the sign.
    typedef logic [LZC_W-1:0] lzc_t;
    typedef logic [4:0] step_t;

    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_e;

    typedef enum logic [2:0] {
        DIG_NEG2 = 3'b110,
        DIG_NEG1 = 3'b111,
        DIG_ZERO = 3'b000,
        DIG_POS1 = 3'b001,
        DIG_POS2 = 3'b010
    } digit_e;

    // true when index a is younger than index b.
    function automatic logic rob_younger(input logic a_ph, input logic [ROB_LO_W-1:0] a_lo,
                                         input logic b_ph, input logic [ROB_LO_W-1:0] b_lo);
        return (a_ph == b_ph) ? (a_lo > b_lo) : (a_lo < b_lo);
    endfunction

endpackage

// ==== design/div_stage_if.sv ====
`timescale 1ns/100ps

interface div_stage_if #(
    parameter int ROB_W = 6,
    parameter int PREG_W = 6
);
    div_pkg::pa_t pa;
    div_pkg::word_t b;
    div_pkg::lzc_t lzc;
    logic sext;
    logic rem;
    logic zero;
    logic ov;
    logic ha; // dividend sign.
    logic hb; // divisor sign.
    div_pkg::word_t src1;
    div_pkg::word_t q_pos;
    div_pkg::word_t q_neg;
    logic [PREG_W-1:0] rd;
    logic we;
    logic [ROB_W-1:0] rob_idx;

    modport src (output pa, b, lzc, sext, rem, zero, ov, ha, hb, src1, q_pos, q_neg,
                 rd, we, rob_idx);
    modport dst (input pa, b, lzc, sext, rem, zero, ov, ha, hb, src1, q_pos, q_neg,
                 rd, we, rob_idx);
endinterface

// ==== design/div_prep.sv ====
`timescale 1ns/100ps

module div_prep #(
    parameter int ROB_W = 6,
    parameter int PREG_W = 6
) (
    input div_pkg::div_op_e op_i,
    input div_pkg::word_t rs1_i,
    input div_pkg::word_t rs2_i,
    input logic [PREG_W-1:0] rd_i,
    input logic we_i,
    input logic [ROB_W-1:0] rob_idx_i,
    div_stage_if.src out
);
    logic sext;
    div_pkg::word_t abs_a;
    div_pkg::word_t abs_b;
    div_pkg::lzc_t lzc;
    logic found;

    assign sext = (op_i == div_pkg::OP_DIV) || (op_i == div_pkg::OP_REM);
    assign abs_a = (sext && rs1_i[div_pkg::XLEN-1]) ? -rs1_i : rs1_i;
    assign abs_b = (sext && rs2_i[div_pkg::XLEN-1]) ? -rs2_i : rs2_i;

    // the first set bit from the top decides the normalization shift.
    always_comb begin
        lzc = '0;
        found = 1'b0;
        for (int i = div_pkg::XLEN - 1; i >= 0; i--) begin
            if (!found && abs_b[i]) begin
                found = 1'b1;
                lzc = div_pkg::lzc_t'(div_pkg::XLEN - 1 - i);
            end
        end
    end

    assign out.pa = div_pkg::pa_t'(abs_a) << lzc;
    assign out.b = abs_b << lzc;
    assign out.lzc = lzc;
    assign out.sext = sext;
    assign out.rem = (op_i == div_pkg::OP_REM) || (op_i == div_pkg::OP_REMU);
    assign out.zero = (rs2_i == '0);
    assign out.ov = sext && (rs1_i == 32'h8000_0000) && (rs2_i == 32'hffff_ffff);
    assign out.ha = rs1_i[div_pkg::XLEN-1];
    assign out.hb = rs2_i[div_pkg::XLEN-1];
    assign out.src1 = rs1_i;
    assign out.q_pos = '0;
    assign out.q_neg = '0;
    assign out.rd = rd_i;
    assign out.we = we_i;
    assign out.rob_idx = rob_idx_i;

endmodule

// ==== design/div_qsel.sv ====
`timescale 1ns/100ps

module div_qsel (
    input logic [3:0] b_i,
    input logic signed [5:0] p_i,
    output div_pkg::digit_e q_o
);
    // lowest partial remainder that selects -1, 0, +1 and +2.
    logic signed [5:0] t_neg1;
    logic signed [5:0] t_zero;
    logic signed [5:0] t_pos1;
    logic signed [5:0] t_pos2;

    always_comb begin
        case (b_i)
            4'b1001: {t_neg1, t_zero, t_pos1, t_pos2} = {-6'sd7, -6'sd2, 6'sd3, 6'sd7};
            4'b1010: {t_neg1, t_zero, t_pos1, t_pos2} = {-6'sd8, -6'sd2, 6'sd3, 6'sd8};
            4'b1011: {t_neg1, t_zero, t_pos1, t_pos2} = {-6'sd8, -6'sd2, 6'sd3, 6'sd9};
            4'b1100: {t_neg1, t_zero, t_pos1, t_pos2} = {-6'sd9, -6'sd3, 6'sd4, 6'sd10};
            4'b1101: {t_neg1, t_zero, t_pos1, t_pos2} = {-6'sd10, -6'sd3, 6'sd4, 6'sd10};
            4'b1110: {t_neg1, t_zero, t_pos1, t_pos2} = {-6'sd10, -6'sd3, 6'sd4, 6'sd11};
            4'b1111: {t_neg1, t_zero, t_pos1, t_pos2} = {-6'sd11, -6'sd3, 6'sd5, 6'sd12};
            default: {t_neg1, t_zero, t_pos1, t_pos2} = {-6'sd6, -6'sd2, 6'sd2, 6'sd6};
        endcase
    end

    // the overlap regions of the table are resolved toward the smaller digit.
    always_comb begin
        if (p_i >= t_pos2) begin
            q_o = div_pkg::DIG_POS2;
        end else if (p_i >= t_pos1) begin
            q_o = div_pkg::DIG_POS1;
        end else if (p_i >= t_zero) begin
            q_o = div_pkg::DIG_ZERO;
        end else if (p_i >= t_neg1) begin
            q_o = div_pkg::DIG_NEG1;
        end else begin
            q_o = div_pkg::DIG_NEG2;
        end
    end

endmodule

// ==== design/div_iter.sv ====
`timescale 1ns/100ps

module div_iter #(
    parameter int ROB_W = 6,
    parameter int PREG_W = 6
) (
    input logic clk,
    input logic rst,
    input logic load_i,
    input logic step_i,
    input div_pkg::step_t pos_i,
    div_stage_if.dst in,
    div_stage_if.src out
);
    div_pkg::pa_t pa, pa_shift, pa_n;
    div_pkg::pa_t b_1x; // divisor aligned to the remainder.
    div_pkg::word_t b;
    div_pkg::word_t q_pos, q_neg, weight;
    div_pkg::lzc_t lzc;
    div_pkg::word_t src1;
    div_pkg::digit_e dig;
    logic sext, rem, zero, ov, ha, hb, we;
    logic [PREG_W-1:0] rd;
    logic [ROB_W-1:0] rob_idx;

    div_qsel qsel_i (
        .b_i(b[div_pkg::XLEN-1 -: 4]),
        .p_i(pa[2*div_pkg::XLEN -: 6]),
        .q_o(dig)
    );

    assign pa_shift = pa << 2;
    assign b_1x = {1'b0, b, {div_pkg::XLEN{1'b0}}};
    assign weight = div_pkg::word_t'(1) << {pos_i, 1'b0};

    always_comb begin
        case (dig)
            div_pkg::DIG_NEG2: pa_n = pa_shift + (b_1x << 1);
            div_pkg::DIG_NEG1: pa_n = pa_shift + b_1x;
            div_pkg::DIG_POS1: pa_n = pa_shift - b_1x;
            div_pkg::DIG_POS2: pa_n = pa_shift - (b_1x << 1);
            default: pa_n = pa_shift;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {sext, rem, zero, ov, we} <= '0;
        end else if (load_i) begin
            {sext, rem, zero, ov, we} <= {in.sext, in.rem, in.zero, in.ov, in.we};
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            pa <= in.pa;
            b <= in.b;
            lzc <= in.lzc;
            q_pos <= in.q_pos;
            q_neg <= in.q_neg;
            {ha, hb} <= {in.ha, in.hb};
            src1 <= in.src1;
            rd <= in.rd;
            rob_idx <= in.rob_idx;
        end else if (step_i) begin
            pa <= pa_n;
            if (dig == div_pkg::DIG_POS1 || dig == div_pkg::DIG_POS2) begin
                q_pos <= q_pos + ((dig == div_pkg::DIG_POS2) ? weight << 1 : weight);
            end
            if (dig == div_pkg::DIG_NEG1 || dig == div_pkg::DIG_NEG2) begin
                q_neg <= q_neg + ((dig == div_pkg::DIG_NEG2) ? weight << 1 : weight);
            end
        end
    end

    assign out.pa = pa;
    assign out.b = b;
    assign out.lzc = lzc;
    assign out.sext = sext;
    assign out.rem = rem;
    assign out.zero = zero;
    assign out.ov = ov;
    assign out.ha = ha;
    assign out.hb = hb;
    assign out.src1 = src1;
    assign out.q_pos = q_pos;
    assign out.q_neg = q_neg;
    assign out.rd = rd;
    assign out.we = we;
    assign out.rob_idx = rob_idx;

endmodule

// ==== design/div_step_counter.sv ====
`timescale 1ns/100ps

module div_step_counter (
    input logic clk,
    input logic rst,
    input logic load_i,
    input logic step_i,
    output div_pkg::step_t pos_o,
    output logic last_o
);
    div_pkg::step_t cnt; // iterations still to run.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (load_i) begin
            cnt <= div_pkg::step_t'(div_pkg::ITERS);
        end else if (step_i && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign pos_o = cnt - 1'b1; // the first step weights the top digit pair.
    assign last_o = (cnt == div_pkg::step_t'(1));

endmodule

// ==== design/div_ctrl.sv ====
`timescale 1ns/100ps

module div_ctrl #(
    parameter int ROB_W = 6
) (
    input logic clk,
    input logic rst,
    input logic en_i,
    input logic [ROB_W-1:0] rob_idx_i,
    input logic redirect_i,
    input logic [ROB_W-1:0] redirect_idx_i,
    input logic last_i,
    output logic load_o,
    output logic step_o,
    output logic ready_o,
    output logic wakeup_o,
    output logic finish_o
);
    typedef enum logic {ST_IDLE, ST_BUSY} state_e;

    state_e state;
    logic [ROB_W-1:0] tag;
    logic flush;

    assign load_o = en_i && ready_o;
    assign step_o = (state == ST_BUSY);
    assign flush = step_o && redirect_i && div_pkg::rob_younger(
        tag[ROB_W-1], div_pkg::ROB_LO_W'(tag[ROB_W-2:0]),
        redirect_idx_i[ROB_W-1], div_pkg::ROB_LO_W'(redirect_idx_i[ROB_W-2:0]));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            ready_o <= 1'b1;
            finish_o <= 1'b0;
            tag <= '0;
        end else begin
            finish_o <= 1'b0;
            if (load_o) begin
                state <= ST_BUSY;
                ready_o <= 1'b0;
                tag <= rob_idx_i;
            end else if (flush) begin
                state <= ST_IDLE; // killed, so no finish pulse.
                ready_o <= 1'b1;
            end else if (step_o && last_i) begin
                state <= ST_IDLE;
                ready_o <= 1'b1;
                finish_o <= 1'b1;
            end
        end
    end

    assign wakeup_o = finish_o;

endmodule

// ==== design/div_post.sv ====
`timescale 1ns/100ps

module div_post #(
    parameter int ROB_W = 6,
    parameter int PREG_W = 6
) (
    input logic clk,
    input logic rst,
    input logic finish_i,
    div_stage_if.dst in,
    input logic redirect_i,
    input logic [ROB_W-1:0] redirect_idx_i,
    output logic wb_en_o,
    output logic wb_we_o,
    output logic [PREG_W-1:0] wb_rd_o,
    output logic [ROB_W-1:0] wb_rob_idx_o,
    output div_pkg::word_t wb_res_o
);
    localparam int XLEN = div_pkg::XLEN;

    div_pkg::pa_t pa_fix;
    div_pkg::word_t q_neg_fix, q_p, q_n, q, r_mag, r, res;
    logic en_q, kill_in, kill_out;

    // one add-back step when the last remainder went negative.
    assign pa_fix = (in.pa[2*XLEN] ? in.pa + {1'b0, in.b, {XLEN{1'b0}}} : in.pa) >> in.lzc;
    assign q_neg_fix = in.pa[2*XLEN] ? in.q_neg + 1'b1 : in.q_neg;
    assign q_p = (in.sext && (in.ha ^ in.hb)) ? q_neg_fix : in.q_pos;
    assign q_n = (in.sext && (in.ha ^ in.hb)) ? in.q_pos : q_neg_fix;
    assign r_mag = pa_fix[2*XLEN-1 -: XLEN];

    assign q = in.zero ? '1 : in.ov ? in.src1 : q_p - q_n;
    assign r = in.zero ? in.src1 : in.ov ? '0 : (in.sext && in.ha) ? -r_mag : r_mag;
    assign res = in.rem ? r : q;

    assign kill_in = redirect_i && div_pkg::rob_younger(
        in.rob_idx[ROB_W-1], div_pkg::ROB_LO_W'(in.rob_idx[ROB_W-2:0]),
        redirect_idx_i[ROB_W-1], div_pkg::ROB_LO_W'(redirect_idx_i[ROB_W-2:0]));
    assign kill_out = redirect_i && div_pkg::rob_younger(
        wb_rob_idx_o[ROB_W-1], div_pkg::ROB_LO_W'(wb_rob_idx_o[ROB_W-2:0]),
        redirect_idx_i[ROB_W-1], div_pkg::ROB_LO_W'(redirect_idx_i[ROB_W-2:0]));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en_q <= 1'b0;
        end else begin
            en_q <= finish_i && !kill_in;
        end
    end

    always_ff @(posedge clk) begin
        wb_res_o <= res;
        wb_we_o <= in.we;
        wb_rd_o <= in.rd;
        wb_rob_idx_o <= in.rob_idx;
    end

    assign wb_en_o = en_q && !kill_out; // a redirect in the output cycle still kills it.

endmodule

// ==== design/div_unit.sv ====
`timescale 1ns/100ps

module div_unit #(
    parameter int ROB_W = 6,
    parameter int PREG_W = 6
) (
    input logic clk,
    input logic rst,
    input logic en_i,
    input div_pkg::div_op_e op_i,
    input div_pkg::word_t rs1_i,
    input div_pkg::word_t rs2_i,
    input logic [PREG_W-1:0] rd_i,
    input logic we_i,
    input logic [ROB_W-1:0] rob_idx_i,
    input logic redirect_i,
    input logic [ROB_W-1:0] redirect_idx_i,
    output logic ready_o,
    output logic wakeup_o,
    output logic [PREG_W-1:0] wakeup_rd_o,
    output logic wakeup_we_o,
    output logic wb_en_o,
    output logic wb_we_o,
    output logic [PREG_W-1:0] wb_rd_o,
    output logic [ROB_W-1:0] wb_rob_idx_o,
    output div_pkg::word_t wb_res_o
);
    logic load, step, last, finish;
    div_pkg::step_t pos;

    div_stage_if #(.ROB_W(ROB_W), .PREG_W(PREG_W)) prep_bus ();
    div_stage_if #(.ROB_W(ROB_W), .PREG_W(PREG_W)) iter_bus ();

    div_prep #(.ROB_W(ROB_W), .PREG_W(PREG_W)) prep_i (
        .op_i(op_i), .rs1_i(rs1_i), .rs2_i(rs2_i), .rd_i(rd_i), .we_i(we_i),
        .rob_idx_i(rob_idx_i), .out(prep_bus.src)
    );

    div_iter #(.ROB_W(ROB_W), .PREG_W(PREG_W)) iter_i (
        .clk(clk), .rst(rst), .load_i(load), .step_i(step), .pos_i(pos),
        .in(prep_bus.dst), .out(iter_bus.src)
    );

    div_step_counter counter_i (
        .clk(clk), .rst(rst), .load_i(load), .step_i(step), .pos_o(pos), .last_o(last)
    );

    div_ctrl #(.ROB_W(ROB_W)) ctrl_i (
        .clk(clk), .rst(rst), .en_i(en_i), .rob_idx_i(rob_idx_i), .redirect_i(redirect_i),
        .redirect_idx_i(redirect_idx_i), .last_i(last), .load_o(load), .step_o(step),
        .ready_o(ready_o), .wakeup_o(wakeup_o), .finish_o(finish)
    );

    div_post #(.ROB_W(ROB_W), .PREG_W(PREG_W)) post_i (
        .clk(clk), .rst(rst), .finish_i(finish), .in(iter_bus.dst),
        .redirect_i(redirect_i), .redirect_idx_i(redirect_idx_i), .wb_en_o(wb_en_o),
        .wb_we_o(wb_we_o), .wb_rd_o(wb_rd_o), .wb_rob_idx_o(wb_rob_idx_o),
        .wb_res_o(wb_res_o)
    );

    // the iteration registers still hold the finished tag during the wakeup cycle.
    assign wakeup_rd_o = iter_bus.rd;
    assign wakeup_we_o = iter_bus.we;

endmodule

// ==== verification/div_unit_tb.sv ====
`timescale 1ns/100ps

module div_unit_tb;
    localparam int ROB_W = 6;
    localparam int PREG_W = 6;
    localparam int CLK_PERIOD = 100;
    localparam int RAND_PAIRS = 20;
    localparam int N_OPS = 4 * RAND_PAIRS + 27; // random, corner, timing, paired and flush ops.
    localparam int WATCHDOG_CYCLES = N_OPS * (div_pkg::ITERS + 4) + 100;

    typedef struct packed {
        logic [31:0] res;
        logic [PREG_W-1:0] rd;
        logic we;
        logic [ROB_W-1:0] rob;
    } exp_t;

    logic clk, rst, en_i, we_i, redirect_i;
    div_pkg::div_op_e op_i;
    logic [31:0] rs1_i, rs2_i;
    logic [PREG_W-1:0] rd_i;
    logic [ROB_W-1:0] rob_idx_i, redirect_idx_i;
    logic ready_o, wakeup_o, wakeup_we_o, wb_en_o, wb_we_o;
    logic [PREG_W-1:0] wakeup_rd_o, wb_rd_o;
    logic [ROB_W-1:0] wb_rob_idx_o;
    logic [31:0] wb_res_o;

    integer seed;
    string test_name;
    logic [ROB_W-1:0] rob_ctr;
    logic [31:0] n_issued;

    // timing model of the unit and the results it still owes.
    exp_t exp_q[$];
    exp_t accepted, cur_exp, wb_exp;
    logic m_busy, m_ready, m_wake, m_pend, m_wb_en;
    int m_cnt;

    div_unit dut_i (
        .clk(clk), .rst(rst), .en_i(en_i), .op_i(op_i), .rs1_i(rs1_i), .rs2_i(rs2_i),
        .rd_i(rd_i), .we_i(we_i), .rob_idx_i(rob_idx_i), .redirect_i(redirect_i),
        .redirect_idx_i(redirect_idx_i), .ready_o(ready_o), .wakeup_o(wakeup_o),
        .wakeup_rd_o(wakeup_rd_o), .wakeup_we_o(wakeup_we_o), .wb_en_o(wb_en_o),
        .wb_we_o(wb_we_o), .wb_rd_o(wb_rd_o), .wb_rob_idx_o(wb_rob_idx_o), .wb_res_o(wb_res_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] ref_result(input div_pkg::div_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
        logic is_signed;
        logic [31:0] q;
        logic [31:0] r;
        is_signed = (op == div_pkg::OP_DIV) || (op == div_pkg::OP_REM);
        if (b == 32'd0) begin
            q = '1;
            r = a;
        end else if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;
            r = '0;
        end else if (is_signed) begin
            q = $signed(a) / $signed(b); // truncates toward zero.
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return (op == div_pkg::OP_REM || op == div_pkg::OP_REMU) ? r : q;
    endfunction

    // the top bit of an index is its wrap phase.
    function automatic logic is_younger(input logic [ROB_W-1:0] a, input logic [ROB_W-1:0] b);
        if (a[ROB_W-1] == b[ROB_W-1]) begin
            return a[ROB_W-2:0] > b[ROB_W-2:0];
        end
        return a[ROB_W-2:0] < b[ROB_W-2:0];
    endfunction

    task automatic stop_failed;
        $display("Checks failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, exp, act);
        stop_failed();
    endtask

    always_comb accepted = '{res: ref_result(op_i, rs1_i, rs2_i), rd: rd_i, we: we_i,
                             rob: rob_idx_i};
    assign m_wb_en = m_pend && !(redirect_i && is_younger(wb_exp.rob, redirect_idx_i));

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_busy <= 1'b0;
            m_ready <= 1'b1;
            m_wake <= 1'b0;
            m_pend <= 1'b0;
            m_cnt <= 0;
            exp_q.delete();
        end else begin
            m_wake <= 1'b0;
            m_pend <= 1'b0;
            if (m_wake) begin // the finished operation moves to the output stage.
                wb_exp <= exp_q.pop_front();
                m_pend <= !(redirect_i && is_younger(cur_exp.rob, redirect_idx_i));
            end
            if (en_i && m_ready) begin
                m_busy <= 1'b1;
                m_ready <= 1'b0;
                m_cnt <= div_pkg::ITERS;
                cur_exp <= accepted;
                exp_q.push_back(accepted);
            end else if (m_busy && redirect_i && is_younger(cur_exp.rob, redirect_idx_i)) begin
                m_busy <= 1'b0;
                m_ready <= 1'b1;
                void'(exp_q.pop_back());
            end else if (m_busy) begin
                m_cnt <= m_cnt - 1;
                if (m_cnt == 1) begin
                    m_busy <= 1'b0;
                    m_ready <= 1'b1;
                    m_wake <= 1'b1;
                end
            end
        end
    end

    ready_chk: assert property (@(posedge clk) disable iff (rst) ready_o == m_ready)
        else report_mismatch("ready_o", $sampled(m_ready), $sampled(ready_o));
    wake_chk: assert property (@(posedge clk) disable iff (rst) wakeup_o == m_wake)
        else report_mismatch("wakeup_o", $sampled(m_wake), $sampled(wakeup_o));
    wake_tag_chk: assert property (@(posedge clk) disable iff (rst)
        m_wake |-> (wakeup_rd_o == cur_exp.rd && wakeup_we_o == cur_exp.we))
        else report_mismatch("wakeup tag", $sampled({cur_exp.rd, cur_exp.we}),
                             $sampled({wakeup_rd_o, wakeup_we_o}));
    wb_en_chk: assert property (@(posedge clk) disable iff (rst) wb_en_o == m_wb_en)
        else report_mismatch("wb_en_o", $sampled(m_wb_en), $sampled(wb_en_o));
    wb_res_chk: assert property (@(posedge clk) disable iff (rst)
        m_wb_en |-> wb_res_o == wb_exp.res)
        else report_mismatch("wb_res_o", $sampled(wb_exp.res), $sampled(wb_res_o));
    wb_tag_chk: assert property (@(posedge clk) disable iff (rst)
        m_wb_en |-> (wb_rd_o == wb_exp.rd && wb_we_o == wb_exp.we && wb_rob_idx_o == wb_exp.rob))
        else report_mismatch("wb tag", $sampled({wb_exp.rd, wb_exp.we, wb_exp.rob}),
                             $sampled({wb_rd_o, wb_we_o, wb_rob_idx_o}));

    // called at a rising edge, returns at the edge that accepts the operation.
    task automatic issue(input div_pkg::div_op_e op, input logic [31:0] a, input logic [31:0] b,
                         input logic [ROB_W-1:0] rob);
        en_i <= 1'b1;
        op_i <= op;
        rs1_i <= a;
        rs2_i <= b;
        rd_i <= n_issued[PREG_W-1:0];
        we_i <= !n_issued[2];
        rob_idx_i <= rob;
        n_issued++;
        do @(posedge clk); while (!ready_o);
        en_i <= 1'b0;
    endtask

    // ready comes back with the wakeup, and the output stage needs one more cycle.
    task automatic wait_done;
        do @(posedge clk); while (!ready_o);
        repeat (2) @(posedge clk);
    endtask

    task automatic run_one(input div_pkg::div_op_e op, input logic [31:0] a,
                           input logic [31:0] b);
        rob_ctr++;
        issue(op, a, b, rob_ctr);
        wait_done();
    endtask

    task automatic run_random;
        logic [31:0] a;
        logic [31:0] b;
        test_name = "unsigned";
        for (int i = 0; i < RAND_PAIRS; i++) begin
            a = $random(seed);
            b = $unsigned($random(seed)) >> (i % 32); // many leading zeros in the divisor.
            run_one(div_pkg::OP_DIVU, a, b);
            run_one(div_pkg::OP_REMU, a, b);
        end
        test_name = "signed";
        for (int i = 0; i < RAND_PAIRS; i++) begin
            a = $random(seed);
            b = $random(seed);
            a[31] = i[0];
            b[31] = i[1];
            b = $signed(b) >>> (i % 24);
            run_one(div_pkg::OP_DIV, a, b);
            run_one(div_pkg::OP_REM, a, b);
        end
    endtask

    task automatic redirect_in_flight(input logic [ROB_W-1:0] rob, input logic [ROB_W-1:0] idx,
                                      input logic at_output);
        issue(div_pkg::OP_DIV, $random(seed), 32'd13, rob);
        if (at_output) begin
            do @(posedge clk); while (!wakeup_o);
        end else begin
            repeat (5) @(posedge clk);
        end
        redirect_i <= 1'b1;
        redirect_idx_i <= idx;
        @(posedge clk);
        redirect_i <= 1'b0;
        wait_done();
    endtask

    initial begin
        seed = 32'hec82_ae66;
        test_name = "reset";
        rob_ctr = '0;
        n_issued = '0;
        clk = 1'b0;
        rst <= 1'b1;
        en_i <= 1'b0;
        op_i <= div_pkg::OP_DIV;
        rs1_i <= '0;
        rs2_i <= '0;
        rd_i <= '0;
        we_i <= 1'b0;
        rob_idx_i <= '0;
        redirect_i <= 1'b0;
        redirect_idx_i <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_name = "timing";
        run_one(div_pkg::OP_DIVU, 32'd100, 32'd7);
        run_random();

        test_name = "corner";
        for (int k = 0; k < 4; k++) begin
            run_one(div_pkg::div_op_e'(k), $random(seed), 32'd0);
            run_one(div_pkg::div_op_e'(k), 32'h8000_0000, 32'd0);
            run_one(div_pkg::div_op_e'(k), 32'h8000_0000, 32'hffff_ffff);
            run_one(div_pkg::div_op_e'(k), 32'h7fff_ffff, 32'd1);
            run_one(div_pkg::div_op_e'(k), 32'h0000_0007, 32'hffff_fffe);
        end

        test_name = "back to back";
        issue(div_pkg::OP_DIV, 32'hffff_ff9c, 32'd9, 6'h11);
        issue(div_pkg::OP_REMU, 32'hdead_beef, 32'h0000_0123, 6'h12); // en_i stays high.
        wait_done();

        test_name = "flush";
        redirect_in_flight(6'h05, 6'h03, 1'b0); // older redirect kills it.
        redirect_in_flight(6'h05, 6'h09, 1'b0); // younger redirect leaves it alone.
        redirect_in_flight(6'h21, 6'h1e, 1'b0);
        redirect_in_flight(6'h10, 6'h0c, 1'b1);

        @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            report_mismatch("pending results", 32'd0, exp_q.size());
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        stop_failed();
    end

endmodule

// ==== project.f ====
design/div_pkg.sv
design/div_stage_if.sv
design/div_prep.sv
design/div_qsel.sv
design/div_iter.sv
design/div_step_counter.sv
design/div_ctrl.sv
design/div_post.sv
design/div_unit.sv
verification/div_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module div_unit_tb -o div_unit_tb_sim

./obj_dir/div_unit_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
    exit 0
else
    exit 1
fi
